//--- espi_cfg_pkg.sv
//--------------------------------------------------------------------------
// eSPI link constants and base types
//--------------------------------------------------------------------------

package espi_cfg_pkg;

    // ------------------------------------------------------------------------
    // link constants
    // ------------------------------------------------------------------------
    localparam int lane_count = 4;      // I/O[3:0]
    localparam int byte_w     = 8;
    localparam int tar_cycles = 2;      // turn-around length in clocks

    // ------------------------------------------------------------------------
    // width typedefs
    // ------------------------------------------------------------------------
    typedef logic [byte_w-1:0]     espi_byte_t;
    typedef logic [lane_count-1:0] lane_vec_t;
    typedef logic [2:0]            slot_cnt_t;   // clock index inside one byte

    // sent in place of a response byte that is not there yet
    localparam espi_byte_t wait_state_byte = 8'h0F;

    // lane mode, same encoding as the config register field
    typedef enum logic [1:0] {
        io_single = 2'b00,      // 8 clocks per byte
        io_dual   = 2'b01,      // 4 clocks per byte
        io_quad   = 2'b10       // 2 clocks per byte
    } io_mode_e;

    // index of the final clock of a byte for the given lane mode
    function automatic slot_cnt_t last_slot(io_mode_e mode);
        case (mode)
            io_dual: return slot_cnt_t'(3);
            io_quad: return slot_cnt_t'(1);
            default: return slot_cnt_t'(7);    // single and reserved code
        endcase
    endfunction

endpackage

//--- espi_link_pkg.sv
//--------------------------------------------------------------------------
// eSPI link phase and bundle types
//--------------------------------------------------------------------------

package espi_link_pkg;

    // transaction phase as seen by the link layer
    typedef enum logic [2:0] {
        ph_idle       = 3'd0,
        ph_request    = 3'd1,   // command bytes coming in
        ph_tar        = 3'd2,   // bus turn-around
        ph_response   = 3'd3,   // response bytes going out
        ph_drive_high = 3'd4    // hold active lanes high until cs_n rises
    } link_phase_e;

    // byte handed upstream by the deserializer
    typedef struct packed {
        logic                     valid;
        espi_cfg_pkg::espi_byte_t data;
        logic                     crc_end;   // request ends with this byte
    } rx_byte_s;

    // byte pushed by the response producer
    typedef struct packed {
        logic                     valid;
        espi_cfg_pkg::espi_byte_t data;
        logic                     last;
    } resp_byte_s;

    // controller to serializer
    typedef struct packed {
        link_phase_e phase;
        logic        byte_start;            // load next byte this cycle
    } tx_cmd_s;

endpackage

//--- espi_link_top.sv
//--------------------------------------------------------------------------
// eSPI link layer, SPI clock domain
//--------------------------------------------------------------------------

`timescale 1ns/10ps

module espi_link_top #(
    parameter int RESP_DEPTH = 4        // response buffer depth and initial credits
) (
    input  logic                       espi_clk,
    input  logic                       spi_domain_reset_n,
    input  logic                       cs_n,
    input  espi_cfg_pkg::io_mode_e     io_mode,
    input  espi_cfg_pkg::lane_vec_t    data_in,
    input  logic                       crc_end,
    input  espi_link_pkg::resp_byte_s  resp,
    output espi_link_pkg::rx_byte_s    rx_byte,
    output logic                       resp_credit,
    output espi_cfg_pkg::lane_vec_t    data_out,
    output espi_cfg_pkg::lane_vec_t    data_oe
);

    espi_link_pkg::tx_cmd_s tx_cmd;
    logic                   last_sent;

    espi_rx_deser i_espi_rx_deser (
        .espi_clk           (espi_clk),
        .spi_domain_reset_n (spi_domain_reset_n),
        .cs_n               (cs_n),
        .io_mode            (io_mode),
        .data_in            (data_in),
        .crc_end            (crc_end),
        .rx_byte            (rx_byte)
    );

    espi_phase_ctrl i_espi_phase_ctrl (
        .espi_clk           (espi_clk),
        .spi_domain_reset_n (spi_domain_reset_n),
        .cs_n               (cs_n),
        .io_mode            (io_mode),
        .rx_byte            (rx_byte),
        .last_sent          (last_sent),
        .tx_cmd             (tx_cmd)
    );

    espi_tx_ser #(
        .RESP_DEPTH (RESP_DEPTH)
    ) i_espi_tx_ser (
        .espi_clk           (espi_clk),
        .spi_domain_reset_n (spi_domain_reset_n),
        .cs_n               (cs_n),
        .io_mode            (io_mode),
        .tx_cmd             (tx_cmd),
        .resp               (resp),
        .resp_credit        (resp_credit),
        .last_sent          (last_sent),
        .data_out           (data_out),
        .data_oe            (data_oe)
    );

endmodule

//--- espi_phase_ctrl.sv
//--------------------------------------------------------------------------
// eSPI transaction phase controller
//--------------------------------------------------------------------------

`timescale 1ns/10ps

module espi_phase_ctrl (
    input  logic                    espi_clk,
    input  logic                    spi_domain_reset_n,
    input  logic                    cs_n,
    input  espi_cfg_pkg::io_mode_e  io_mode,
    input  espi_link_pkg::rx_byte_s rx_byte,
    input  logic                    last_sent,
    output espi_link_pkg::tx_cmd_s  tx_cmd
);

    localparam int tar_w = $clog2(espi_cfg_pkg::tar_cycles + 1);
    localparam logic [tar_w-1:0] tar_last = tar_w'(espi_cfg_pkg::tar_cycles - 1);

    espi_link_pkg::link_phase_e phase_q;
    espi_link_pkg::link_phase_e phase_nxt;
    logic [tar_w-1:0]           tar_cnt_q;
    logic [tar_w-1:0]           tar_cnt_nxt;
    espi_cfg_pkg::slot_cnt_t    slot_q;
    espi_cfg_pkg::slot_cnt_t    slot_nxt;
    espi_cfg_pkg::slot_cnt_t    slot_last;
    logic                       start_nxt;

    assign slot_last = espi_cfg_pkg::last_slot(io_mode);

    // ------------------------------------------------------------------------
    // phase FSM
    // ------------------------------------------------------------------------
    always_comb begin
        phase_nxt   = phase_q;
        tar_cnt_nxt = tar_cnt_q;
        case (phase_q)
            espi_link_pkg::ph_idle: begin
                if (!cs_n) phase_nxt = espi_link_pkg::ph_request;
            end
            espi_link_pkg::ph_request: begin
                if (rx_byte.valid && rx_byte.crc_end) begin
                    phase_nxt   = espi_link_pkg::ph_tar;
                    tar_cnt_nxt = '0;
                end
            end
            espi_link_pkg::ph_tar: begin
                if (tar_cnt_q == tar_last) phase_nxt = espi_link_pkg::ph_response;
                else tar_cnt_nxt = tar_cnt_q + 1'b1;
            end
            espi_link_pkg::ph_response: begin
                if (last_sent) phase_nxt = espi_link_pkg::ph_drive_high;
            end
            espi_link_pkg::ph_drive_high: begin
                phase_nxt = espi_link_pkg::ph_drive_high;   // held until cs_n rises
            end
            default: phase_nxt = espi_link_pkg::ph_idle;
        endcase
        if (cs_n) phase_nxt = espi_link_pkg::ph_idle;   // abort from any phase
    end

    // byte boundary tracking inside the response
    always_comb begin
        if (phase_q != espi_link_pkg::ph_response) slot_nxt = '0;
        else if (slot_q == slot_last) slot_nxt = '0;
        else slot_nxt = slot_q + 1'b1;
    end

    assign start_nxt = (phase_nxt == espi_link_pkg::ph_response) && (slot_nxt == '0);

    always_ff @(posedge espi_clk or negedge spi_domain_reset_n) begin
        if (!spi_domain_reset_n) begin
            phase_q   <= espi_link_pkg::ph_idle;
            tar_cnt_q <= '0;
            slot_q    <= '0;
        end else begin
            phase_q   <= phase_nxt;
            tar_cnt_q <= tar_cnt_nxt;
            slot_q    <= slot_nxt;
        end
    end

    // look-ahead command, the serializer registers it on the same edge
    assign tx_cmd.phase      = phase_nxt;
    assign tx_cmd.byte_start = start_nxt;

endmodule

//--- espi_rx_deser.sv
//--------------------------------------------------------------------------
// eSPI receive deserializer
//--------------------------------------------------------------------------

`timescale 1ns/10ps

module espi_rx_deser (
    input  logic                    espi_clk,
    input  logic                    spi_domain_reset_n,
    input  logic                    cs_n,
    input  espi_cfg_pkg::io_mode_e  io_mode,
    input  espi_cfg_pkg::lane_vec_t data_in,
    input  logic                    crc_end,
    output espi_link_pkg::rx_byte_s rx_byte
);

    espi_cfg_pkg::slot_cnt_t  slot_q;
    espi_cfg_pkg::slot_cnt_t  slot_last;
    espi_cfg_pkg::espi_byte_t shift_q;
    espi_cfg_pkg::espi_byte_t shift_nxt;
    logic                     byte_done;
    logic                     valid_q;

    assign slot_last = espi_cfg_pkg::last_slot(io_mode);
    assign byte_done = (slot_q == slot_last);

    // msb first, the lowest lanes carry the newest bits
    always_comb begin
        case (io_mode)
            espi_cfg_pkg::io_dual: shift_nxt = {shift_q[5:0], data_in[1:0]};
            espi_cfg_pkg::io_quad: shift_nxt = {shift_q[3:0], data_in[3:0]};
            default:               shift_nxt = {shift_q[6:0], data_in[0]};
        endcase
    end

    always_ff @(posedge espi_clk or negedge spi_domain_reset_n) begin
        if (!spi_domain_reset_n) begin
            slot_q  <= '0;
            shift_q <= '0;
            valid_q <= 1'b0;
        end else if (cs_n) begin
            slot_q  <= '0;              // next frame starts byte aligned
            shift_q <= '0;
            valid_q <= 1'b0;
        end else begin
            shift_q <= shift_nxt;
            valid_q <= byte_done;
            slot_q  <= byte_done ? '0 : slot_q + 1'b1;
        end
    end

    // the completed byte sits in the shifter during the valid cycle
    assign rx_byte.valid   = valid_q;
    assign rx_byte.data    = shift_q;
    assign rx_byte.crc_end = crc_end;   // decoder flag, same cycle as valid

endmodule

//--- espi_tx_ser.sv
//--------------------------------------------------------------------------
// eSPI response serializer
//--------------------------------------------------------------------------

`timescale 1ns/10ps

module espi_tx_ser #(
    parameter int RESP_DEPTH = 4
) (
    input  logic                       espi_clk,
    input  logic                       spi_domain_reset_n,
    input  logic                       cs_n,
    input  espi_cfg_pkg::io_mode_e     io_mode,
    input  espi_link_pkg::tx_cmd_s     tx_cmd,
    input  espi_link_pkg::resp_byte_s  resp,
    output logic                       resp_credit,
    output logic                       last_sent,
    output espi_cfg_pkg::lane_vec_t    data_out,
    output espi_cfg_pkg::lane_vec_t    data_oe
);

    localparam int ptr_w = (RESP_DEPTH > 1) ? $clog2(RESP_DEPTH) : 1;
    localparam int cnt_w = $clog2(RESP_DEPTH + 1);
    localparam logic [ptr_w-1:0] ptr_last = ptr_w'(RESP_DEPTH - 1);

    espi_link_pkg::resp_byte_s fifo_mem [RESP_DEPTH];
    logic [ptr_w-1:0]          wr_ptr_q;
    logic [ptr_w-1:0]          rd_ptr_q;
    logic [cnt_w-1:0]          count_q;
    logic                      fifo_empty;
    logic                      push;
    logic                      pop;
    logic                      credit_q;
    espi_cfg_pkg::espi_byte_t  load_byte;
    logic                      load_last;
    espi_cfg_pkg::espi_byte_t  shift_q;
    espi_cfg_pkg::espi_byte_t  shift_nxt;
    logic                      last_q;
    logic                      drive_q;       // shifting a byte out
    logic                      high_q;        // drive-high after the last byte
    espi_cfg_pkg::slot_cnt_t   slot_q;
    espi_cfg_pkg::slot_cnt_t   slot_last;
    espi_cfg_pkg::lane_vec_t   lane_mask;
    espi_cfg_pkg::lane_vec_t   lane_bits;

    // ------------------------------------------------------------------------
    // response FIFO, one credit back per entry leaving
    // ------------------------------------------------------------------------
    assign fifo_empty = (count_q == '0);
    assign push       = resp.valid;
    assign pop        = !fifo_empty && (tx_cmd.byte_start || cs_n);   // dequeue or flush

    always_ff @(posedge espi_clk) begin
        if (push) fifo_mem[wr_ptr_q] <= resp;
    end

    always_ff @(posedge espi_clk or negedge spi_domain_reset_n) begin
        if (!spi_domain_reset_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_q <= 1'b0;
        end else begin
            if (push) wr_ptr_q <= (wr_ptr_q == ptr_last) ? '0 : wr_ptr_q + 1'b1;
            if (pop) rd_ptr_q <= (rd_ptr_q == ptr_last) ? '0 : rd_ptr_q + 1'b1;
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            credit_q <= pop;
        end
    end

    assign resp_credit = credit_q;
    assign load_byte   = fifo_empty ? espi_cfg_pkg::wait_state_byte : fifo_mem[rd_ptr_q].data;
    assign load_last   = !fifo_empty && fifo_mem[rd_ptr_q].last;

    // ------------------------------------------------------------------------
    // shifter and lane drivers
    // ------------------------------------------------------------------------
    assign slot_last = espi_cfg_pkg::last_slot(io_mode);

    always_comb begin
        case (io_mode)
            espi_cfg_pkg::io_dual: begin
                lane_mask = 4'b0011;
                lane_bits = {2'b00, shift_q[7:6]};
                shift_nxt = {shift_q[5:0], 2'b00};
            end
            espi_cfg_pkg::io_quad: begin
                lane_mask = 4'b1111;
                lane_bits = shift_q[7:4];
                shift_nxt = {shift_q[3:0], 4'b0000};
            end
            default: begin                          // single mode goes out on io[1]
                lane_mask = 4'b0010;
                lane_bits = {2'b00, shift_q[7], 1'b0};
                shift_nxt = {shift_q[6:0], 1'b0};
            end
        endcase
    end

    always_ff @(posedge espi_clk or negedge spi_domain_reset_n) begin
        if (!spi_domain_reset_n) begin
            drive_q <= 1'b0;
            high_q  <= 1'b0;
            last_q  <= 1'b0;
            slot_q  <= '0;
        end else begin
            drive_q <= (tx_cmd.phase == espi_link_pkg::ph_response);
            high_q  <= (tx_cmd.phase == espi_link_pkg::ph_drive_high);
            if (tx_cmd.byte_start) begin
                last_q <= load_last;
                slot_q <= '0;
            end else if (drive_q) begin
                slot_q <= (slot_q == slot_last) ? '0 : slot_q + 1'b1;
            end
        end
    end

    always_ff @(posedge espi_clk) begin
        if (tx_cmd.byte_start) shift_q <= load_byte;
        else if (drive_q) shift_q <= shift_nxt;
    end

    assign last_sent = drive_q && last_q && (slot_q == slot_last);

    always_comb begin
        if (high_q) begin
            data_out = lane_mask;       // all active lanes high
            data_oe  = lane_mask;
        end else if (drive_q) begin
            data_out = lane_bits;
            data_oe  = lane_mask;
        end else begin
            data_out = '0;
            data_oe  = '0;
        end
    end

endmodule

//--- list.f
+incdir+.
espi_cfg_pkg.sv
espi_link_pkg.sv
espi_rx_deser.sv
espi_phase_ctrl.sv
espi_tx_ser.sv
espi_link_top.sv
tb_espi_link.sv

//--- run_sim.sh
#!/bin/sh
# build and run the eSPI link testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f list.f --top-module tb_espi_link -Mdir obj_dir -o sim_espi_link \
    && ./obj_dir/sim_espi_link > sim.log 2>&1
cat sim.log
grep -q "All tests passed" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }

//--- tb_espi_model.svh
//--------------------------------------------------------------------------
// eSPI link testbench model and checks
//--------------------------------------------------------------------------

`ifndef TB_ESPI_MODEL_SVH
`define TB_ESPI_MODEL_SVH

// ----------------------------------------------------------------------------
// model state
// ----------------------------------------------------------------------------
espi_cfg_pkg::espi_byte_t rx_exp_q[$];      // request bytes still to be seen
espi_cfg_pkg::espi_byte_t resp_exp_q[$];    // response bytes fed, in order
bit                       resp_last_q[$];
espi_cfg_pkg::lane_vec_t  tx_mask;          // lanes used by the response
espi_cfg_pkg::lane_vec_t  rx_mask;          // lanes used by the request
espi_cfg_pkg::espi_byte_t sh_byte;
int                       slots;
int                       credits;
int                       tar_wait;
int                       sh_cnt;
int                       waits_before;
bit                       tar_armed;
bit                       in_resp;
bit                       resp_done;
bit                       data_seen;
logic                     cs_prev;

task automatic check_rx_byte(espi_cfg_pkg::espi_byte_t got, espi_cfg_pkg::espi_byte_t exp);
    if (got !== exp)
        abort_run($sformatf("FAIL at %0t: rx byte %02h, expected %02h", $time, got, exp));
endtask

task automatic check_resp_byte(espi_cfg_pkg::espi_byte_t got, espi_cfg_pkg::espi_byte_t exp);
    if (got !== exp)
        abort_run($sformatf("FAIL at %0t: response byte %02h, expected %02h", $time, got, exp));
endtask

task automatic check_lanes(espi_cfg_pkg::lane_vec_t got, espi_cfg_pkg::lane_vec_t exp,
                           string what);
    if (got !== exp)
        abort_run($sformatf("FAIL at %0t: %s is %04b, expected %04b", $time, what, got, exp));
endtask

task automatic check_flag(logic got, logic exp, string what);
    if (got !== exp)
        abort_run($sformatf("FAIL at %0t: %s is %0b, expected %0b", $time, what, got, exp));
endtask

task automatic check_phase_len(int got, int exp, string what);
    if (got != exp)
        abort_run($sformatf("FAIL at %0t: %s took %0d cycles, expected %0d", $time, what,
                            got, exp));
endtask

// takes one reassembled response byte and skips wait states
task automatic take_resp_byte();
    if (sh_byte == espi_cfg_pkg::wait_state_byte) begin
        if (!data_seen) waits_before++;
    end else if (resp_exp_q.size() == 0) begin
        abort_run($sformatf("FAIL at %0t: response byte %02h not fed", $time, sh_byte));
    end else begin
        check_resp_byte(sh_byte, resp_exp_q.pop_front());
        data_seen = 1;
        if (resp_last_q.pop_front()) begin
            in_resp   = 0;
            resp_done = 1;                  // drive-high from the next cycle on
        end
    end
endtask

// called on every falling edge where all DUT outputs are settled
task automatic sample_outputs();
    if (resp.valid) credits--;
    if (resp_credit) credits++;
    if (credits < 0 || credits > resp_depth)
        abort_run($sformatf("FAIL at %0t: credit count %0d out of range", $time, credits));
    if (tar_armed) begin
        tar_wait++;
        if (data_oe != '0) begin
            check_phase_len(tar_wait, espi_cfg_pkg::tar_cycles + 1, "turn-around");
            tar_armed = 0;
            in_resp   = 1;
            sh_cnt    = 0;
        end
    end
    if (rx_byte.valid && rx_exp_q.size() > 0) begin
        check_rx_byte(rx_byte.data, rx_exp_q.pop_front());
        check_flag(rx_byte.crc_end, rx_exp_q.size() == 0, "rx_byte.crc_end");
        if (rx_exp_q.size() == 0) begin     // the crc byte starts the turn-around
            check_lanes(data_oe, '0, "data_oe in crc cycle");
            tar_armed = 1;
            tar_wait  = 0;
        end
    end
    if (in_resp) begin
        check_lanes(data_oe, tx_mask, "data_oe in response");
        case (slots)
            2:       sh_byte = {sh_byte[3:0], data_out};
            4:       sh_byte = {sh_byte[5:0], data_out[1:0]};
            default: sh_byte = {sh_byte[6:0], data_out[1]};
        endcase
        sh_cnt++;
        if (sh_cnt == slots) begin
            sh_cnt = 0;
            take_resp_byte();
        end
    end else if (resp_done && !cs_n) begin
        check_lanes(data_oe, tx_mask, "data_oe in drive-high");
        check_lanes(data_out, tx_mask, "data_out in drive-high");
    end
    if (cs_n && cs_prev) check_lanes(data_oe, '0, "data_oe after cs_n");
    cs_prev = cs_n;
endtask

`endif

//--- tb_espi_link.sv
//--------------------------------------------------------------------------
// eSPI link layer testbench
//--------------------------------------------------------------------------

`timescale 1ns/10ps

module tb_espi_link;

    localparam int n_trans     = 40;
    localparam int cycle_limit = n_trans * 120;

    logic                      espi_clk;
    logic                      spi_domain_reset_n;
    logic                      cs_n;
    espi_cfg_pkg::io_mode_e    io_mode;
    espi_cfg_pkg::lane_vec_t   data_in;
    logic                      crc_end;
    espi_link_pkg::resp_byte_s resp;
    espi_link_pkg::rx_byte_s   rx_byte;
    logic                      resp_credit;
    espi_cfg_pkg::lane_vec_t   data_out;
    espi_cfg_pkg::lane_vec_t   data_oe;
    int                        resp_depth;
    int                        cycle_cnt;

    espi_link_top i_espi_link_top (
        .espi_clk           (espi_clk),
        .spi_domain_reset_n (spi_domain_reset_n),
        .cs_n               (cs_n),
        .io_mode            (io_mode),
        .data_in            (data_in),
        .crc_end            (crc_end),
        .resp               (resp),
        .rx_byte            (rx_byte),
        .resp_credit        (resp_credit),
        .data_out           (data_out),
        .data_oe            (data_oe)
    );

    task automatic abort_run(string line);
        $display("%s", line);
        $display("Some tests failed");
        $fatal(1, "run stopped");
    endtask

    `include "tb_espi_model.svh"

    // ------------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------------
    task automatic drive_request(int nbytes);
        espi_cfg_pkg::espi_byte_t b;
        int bpc;
        int chunk;
        bpc = 8 / slots;
        for (int i = 0; i < nbytes; i++) begin
            b = espi_cfg_pkg::espi_byte_t'($urandom);
            rx_exp_q.push_back(b);
            for (int s = 0; s < slots; s++) begin
                chunk   = (int'(b) >> (8 - bpc * (s + 1))) & ((1 << bpc) - 1);
                data_in <= (espi_cfg_pkg::lane_vec_t'($urandom) & ~rx_mask)  // noise on idle lanes
                           | espi_cfg_pkg::lane_vec_t'(chunk);
                @(posedge espi_clk);
            end
        end
        data_in <= '0;
        crc_end <= 1'b1;                    // decoder flags the crc byte
        @(posedge espi_clk);
        crc_end <= 1'b0;
    endtask

    task automatic feed_responses(int n, bit delayed);
        espi_cfg_pkg::espi_byte_t b;
        int i;
        i = 0;
        if (delayed) begin
            wait (in_resp);
            repeat (9) @(posedge espi_clk); // past at least one byte boundary
        end
        while (i < n) begin
            @(posedge espi_clk);
            if (credits > 0 && ($urandom % 4) != 0) begin
                do b = espi_cfg_pkg::espi_byte_t'($urandom);
                while (b == espi_cfg_pkg::wait_state_byte);
                resp <= '{valid: 1'b1, data: b, last: (i == n - 1)};
                resp_exp_q.push_back(b);
                resp_last_q.push_back(i == n - 1);
                i++;
            end else begin
                resp.valid <= 1'b0;
            end
        end
        @(posedge espi_clk);
        resp <= '0;
    endtask

    task automatic run_transaction();
        espi_cfg_pkg::io_mode_e mode;
        int  nreq;
        int  nresp;
        bit  delayed;
        case ($urandom % 3)
            0: begin mode = espi_cfg_pkg::io_single; slots = 8; tx_mask = 4'b0010; end
            1: begin mode = espi_cfg_pkg::io_dual;   slots = 4; tx_mask = 4'b0011; end
            default: begin mode = espi_cfg_pkg::io_quad; slots = 2; tx_mask = 4'b1111; end
        endcase
        rx_mask = (slots == 8) ? 4'b0001 : tx_mask;
        nreq    = 2 + $urandom % 4;
        nresp   = 1 + $urandom % 6;
        delayed = (($urandom % 3) == 0);
        in_resp      = 0;
        resp_done    = 0;
        data_seen    = 0;
        waits_before = 0;
        @(posedge espi_clk);
        io_mode <= mode;                    // changes only while cs_n is high
        @(posedge espi_clk);
        cs_n <= 1'b0;
        fork
            drive_request(nreq);
            feed_responses(nresp, delayed);
        join
        wait (resp_done);
        repeat (1 + $urandom % 3) @(posedge espi_clk);
        cs_n <= 1'b1;
        repeat (4) @(posedge espi_clk);
        if (delayed && waits_before < 1)
            abort_run($sformatf("FAIL at %0t: no wait state before delayed response", $time));
        if (credits != resp_depth)
            abort_run($sformatf("FAIL at %0t: %0d credits after transaction, expected %0d",
                                $time, credits, resp_depth));
    endtask

    // ------------------------------------------------------------------------
    // clock, monitor and cycle limit
    // ------------------------------------------------------------------------
    initial begin
        espi_clk = 1'b0;
        forever #20 espi_clk = ~espi_clk;
    end

    always @(negedge espi_clk) sample_outputs();

    always @(posedge espi_clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit)
            abort_run("timeout: the run went past its cycle limit without finishing");
    end

    initial begin
        void'($urandom(32'h54be));
        resp_depth         = i_espi_link_top.RESP_DEPTH;
        credits            = resp_depth;   // producer starts full
        cycle_cnt          = 0;
        cs_prev            = 1'b1;
        spi_domain_reset_n = 1'b0;
        cs_n               = 1'b1;
        io_mode            = espi_cfg_pkg::io_single;
        data_in            = '0;
        crc_end            = 1'b0;
        resp               = '0;
        repeat (3) @(posedge espi_clk);
        spi_domain_reset_n <= 1'b1;
        for (int t = 0; t < n_trans; t++) run_transaction();
        $display("All tests passed");
        $finish;
    end

endmodule
